/* tb.f */
+incdir+source
source/timing_ctrl_pkg.sv
source/spi_slave.sv
source/config_regs.sv
source/status_monitor.sv
source/timing_ctrl_top.sv
verif/spi_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run of the timing receiver SPI testbench

TOP := tb_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): tb.f source/*.sv source/*.svh verif/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* verif/tb_top.sv */
// Testbench top for the timing receiver SPI block
// Clock, reset, LCG, SPI master tasks, test sequence and watchdog

`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import timing_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int HALF            = 8;                     // SPI half period in clk cycles
    localparam int FRAME_CYCLES    = (2 * 48 + 3) * HALF;   // Bits, lead-in, tail, gap
    localparam int FRAME_COUNT     = 39;                    // Frames over all tests
    localparam int WATCHDOG_CYCLES = FRAME_COUNT * FRAME_CYCLES * 3 / 2 + 2000;

    logic         clk;
    logic         rst_n;
    logic         spi_sclk;
    logic         spi_mosi;
    logic         spi_cs_n;
    logic         spi_miso;
    logic         irq_n;
    time_status_t sys_status;
    delay_cfg_t   delay_cfg;
    dpll_cfg_t    dpll_cfg;
    gnss_ctrl_t   gnss_ctrl;
    pps_sel_t     pps_sel;
    word_t        lcg_state;
    word_t        rd;               // Last word collected from miso
    int           test_num;
    int           base_checks;
    int           base_errors;

    timing_ctrl_top DUT (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .spi_miso(spi_miso),
        .irq_n(irq_n), .sys_status(sys_status),
        .delay_cfg(delay_cfg), .dpll_cfg(dpll_cfg), .gnss_ctrl(gnss_ctrl), .pps_sel(pps_sel)
    );

    spi_checker chk (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .spi_miso(spi_miso),
        .irq_n(irq_n), .sys_status(sys_status),
        .delay_cfg(delay_cfg), .dpll_cfg(dpll_cfg), .gnss_ctrl(gnss_ctrl), .pps_sel(pps_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Drive point sits 5 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    // Mode 0 bit, miso sampled just before the rising edge
    task automatic spi_bit(input logic mosi_bit, output logic miso_bit);
        spi_sclk = 1'b0;
        spi_mosi = mosi_bit;
        step(HALF);
        miso_bit = spi_miso;
        spi_sclk = 1'b1;
        step(HALF);
    endtask

    task automatic spi_frame(input logic [15:0] cmd, input word_t wdata, output word_t rdata);
        logic b;
        spi_cs_n = 1'b0;
        step(HALF);
        for (int i = 15; i >= 0; i--) begin
            spi_bit(cmd[i], b);
        end
        for (int i = 31; i >= 0; i--) begin
            spi_bit(wdata[i], b);
            rdata[i] = b;
        end
        spi_sclk = 1'b0;
        step(HALF);
        spi_cs_n = 1'b1;            // Back to IDLE
        spi_mosi = 1'b0;
        step(HALF);
    endtask

    task automatic spi_write(input cmd_kind_e kind, input reg_addr_t addr, input word_t data);
        word_t ignored;
        spi_frame({1'b0, kind, addr}, data, ignored);
    endtask

    // STATUS reads leave bit 15 clear, other kinds set it
    task automatic spi_read(input logic [2:0] kind, input reg_addr_t addr, output word_t data);
        spi_frame({kind != 3'd1, kind, addr}, '0, data);
    endtask

    task automatic randomize_time();
        word_t hi;
        hi = next_random();
        sys_status.seconds    = {hi[7:0], next_random()};
        sys_status.subseconds = next_random();
    endtask

    // New time first, then a 3 cycle pulse and a quiet gap
    task automatic pulse_pps();
        randomize_time();
        step(2);
        sys_status.pps = 1'b1;
        step(3);
        sys_status.pps = 1'b0;
        step(20);
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
                 chk.checks - base_checks, chk.errors - base_errors);
        base_checks = chk.checks;
        base_errors = chk.errors;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        rst_n      = 1'b0;
        spi_sclk   = 1'b0;
        spi_mosi   = 1'b0;
        spi_cs_n   = 1'b1;
        sys_status = '0;
        sys_status.sync_locked = 1'b1;
        sys_status.dpll_locked = 1'b1;
        lcg_state   = 32'd61231;
        test_num    = 0;
        base_checks = 0;
        base_errors = 0;
        step(4);
        rst_n = 1'b1;

        step(4);                    // chk looks at the reset values meanwhile
        end_test("reset values");

        for (int round = 0; round < 2; round++) begin
            spi_write(DELAY, 12'd0, next_random());
            spi_write(DELAY, 12'd1, next_random());
            spi_write(DPLL, 12'd0, next_random());
            spi_write(DPLL, 12'd1, next_random());
            spi_write(GNSS, 12'd0, next_random());
            spi_write(GNSS, 12'd1, next_random());
            spi_write(GNSS, 12'd2, next_random());
            spi_write(PPS_SEL, 12'd0, next_random());
            spi_write(PPS_SEL, 12'd1, next_random());
        end
        end_test("config writes");

        randomize_time();
        sys_status.phase_error     = next_random();
        sys_status.frequency_error = next_random();
        for (int a = 0; a <= 5; a++) begin
            spi_read(STATUS, reg_addr_t'(a), rd);
        end
        spi_read(DELAY, 12'd0, rd);     // Non-status kind
        spi_read(STATUS, 12'd10, rd);   // Unused address
        sys_status.phase_error = '0;
        end_test("status reads");

        repeat (3) pulse_pps();
        randomize_time();               // Live time moves on past the captures
        spi_read(STATUS, 12'd7, rd);
        spi_read(STATUS, 12'd8, rd);
        spi_read(STATUS, 12'd9, rd);
        end_test("pps capture");

        spi_write(CONFIG, 12'd2, 32'd1);    // on_pps
        spi_write(CONFIG, 12'd1, 32'd1);    // irq enable
        pulse_pps();                        // chk expects irq_n low here
        spi_read(STATUS, 12'd0, rd);        // Bit 8, then cleared
        spi_write(CONFIG, 12'd2, 32'd2);    // on_error
        sys_status.phase_error = 32'd20000;
        step(4);
        sys_status.phase_error = 32'd0;
        step(4);
        spi_read(STATUS, 12'd0, rd);        // Bit 9
        spi_write(CONFIG, 12'd1, 32'd0);
        end_test("interrupts");

        sys_status.sync_locked = 1'b0;
        sys_status.dpll_locked = 1'b0;
        step(10);
        sys_status.sync_locked = 1'b1;
        sys_status.dpll_locked = 1'b1;
        step(2);
        spi_read(STATUS, 12'd6, rd);
        spi_read(STATUS, 12'd6, rd);        // Same count while locked
        spi_write(CONFIG, 12'd3, 32'd0);    // Clear
        spi_read(STATUS, 12'd6, rd);
        end_test("error counter");

        $display("Done: %0d tests, %0d checks, %0d errors", test_num, chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from frame count and frame length
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d clk cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/spi_checker.sv */
// Testbench checker for the timing receiver SPI block
// Frame decoder on the SPI pins, register reference model,
// expected read word and all comparisons

`default_nettype none

`include "timing_ctrl_macros.svh"

module spi_checker (
    input wire                                clk,
    input wire                                rst_n,
    input wire                                spi_sclk,
    input wire                                spi_mosi,
    input wire                                spi_cs_n,
    input wire                                spi_miso,
    input wire                                irq_n,
    input wire timing_ctrl_pkg::time_status_t sys_status,
    input wire timing_ctrl_pkg::delay_cfg_t   delay_cfg,
    input wire timing_ctrl_pkg::dpll_cfg_t    dpll_cfg,
    input wire timing_ctrl_pkg::gnss_ctrl_t   gnss_ctrl,
    input wire timing_ctrl_pkg::pps_sel_t     pps_sel
);
    timeunit 1ns;
    timeprecision 1ps;
    import timing_ctrl_pkg::*;

    int          checks = 0;
    int          errors = 0;

    // Pin history, one clk back
    logic        sclk_q;
    logic        cs_q;
    logic        pps_q;
    logic [47:0] mosi_bits;     // Command then data, MSB first
    logic [47:0] miso_bits;
    int          nbits;
    int          reset_wait;    // Cycles until reset values are checked
    int          irq_wait;      // Cycles until irq_n is checked after PPS

    // ====================
    // Reference model
    // ====================
    delay_cfg_t  m_delay;
    dpll_cfg_t   m_dpll;
    gnss_ctrl_t  m_gnss;
    pps_sel_t    m_pps_sel;
    irq_cfg_t    m_irq;
    logic [1:0]  m_irq_st;      // Bit 0 PPS, bit 1 phase error
    word_t       m_err_cnt;
    word_t       m_pps_cnt;
    word_t       m_cap_sec;
    word_t       m_cap_sub;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        logic exp_irq_n;
        exp_irq_n = !(m_irq.enable && (m_irq_st != 2'b00));
        check_value("delay_cfg", 64'(delay_cfg), 64'(m_delay));
        check_value("dpll_cfg", 64'(dpll_cfg), 64'(m_dpll));
        check_value("gnss_ctrl", 64'(gnss_ctrl), 64'(m_gnss));
        check_value("pps_sel", 64'(pps_sel), 64'(m_pps_sel));
        check_value("irq_n", 64'(irq_n), 64'(exp_irq_n));
    endtask

    // Expected read word from the status address map
    function automatic word_t expected_read(input reg_addr_t addr);
        word_t w;
        w = '0;
        case (addr)
            12'd0: begin
                w[0]   = 1'b1;
                w[1]   = sys_status.pps;
                w[2]   = sys_status.sync_locked;
                w[3]   = sys_status.dpll_locked;
                w[5]   = m_gnss.enable;         // Bit 4 stays zero
                w[9:8] = m_irq_st;
            end
            12'd1:   w[7:0] = sys_status.seconds[7:0];
            12'd2:   w = sys_status.seconds[39:8];
            12'd3:   w = sys_status.subseconds;
            12'd4:   w = sys_status.phase_error;
            12'd5:   w = sys_status.frequency_error;
            12'd6:   w = m_err_cnt;
            12'd7:   w = m_pps_cnt;
            12'd8:   w = m_cap_sec;
            12'd9:   w = m_cap_sub;
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic apply_write(input cmd_kind_e kind, input reg_addr_t addr, input word_t data);
        case (kind)
            DELAY: begin
                if (addr == 12'd0) m_delay.cable_ns = data;
                if (addr == 12'd1) m_delay.antenna_ns = data;
            end
            GNSS: begin
                if (addr == 12'd0) m_gnss.enable = data[0];
                if (addr == 12'd1) m_gnss.mode = data[2:0];
                if (addr == 12'd2) m_gnss.reset_n = data[0];
            end
            DPLL: begin
                if (addr == 12'd0) m_dpll.kp = data;
                if (addr == 12'd1) m_dpll.ki = data;
            end
            PPS_SEL: begin
                if (addr == 12'd0) m_pps_sel.source = data[1:0];
                if (addr == 12'd1) m_pps_sel.auto_enable = data[0];
            end
            CONFIG: begin
                if (addr == 12'd1) m_irq.enable = data[0];
                if (addr == 12'd2) begin
                    m_irq.on_pps   = data[0];
                    m_irq.on_error = data[1];
                end
                if (addr == 12'd3) m_err_cnt = '0;
            end
            default: ;      // Reserved kinds change nothing
        endcase
    endtask

    // Called once cs_n has risen
    task automatic end_frame();
        logic [15:0] cmd;
        logic [2:0]  kind;
        reg_addr_t   addr;
        word_t       exp;
        cmd  = mosi_bits[47:32];
        kind = cmd[14:12];
        addr = cmd[11:0];
        if (nbits != 48) begin
            errors++;
            $display("SPI frame at %0t ns ended after %0d bits instead of 48", $time, nbits);
        end else if (cmd[15] || kind == 3'd1) begin
            exp = (kind == 3'd1) ? expected_read(addr) : '0;   // Other kinds read zero
            check_value($sformatf("miso word, kind %0d address %0d", kind, addr),
                        64'(miso_bits[31:0]), 64'(exp));
            if (kind == 3'd1 && addr == 12'd0) m_irq_st = 2'b00;  // Clear on read
        end else begin
            apply_write(cmd_kind_e'(kind), addr, mosi_bits[31:0]);
        end
        check_outputs();
    endtask

    // ====================
    // Sampling process
    // ====================
    always @(posedge clk) begin
        if (!rst_n) begin
            m_delay    = '0;
            m_dpll     = '{kp: `TC_KP_DEFAULT, ki: `TC_KI_DEFAULT};
            m_gnss     = '{enable: 1'b0, mode: 3'd0, reset_n: 1'b1};
            m_pps_sel  = '{source: 2'd0, auto_enable: 1'b1};
            m_irq      = '0;
            m_irq_st   = 2'b00;
            m_err_cnt  = '0;
            m_pps_cnt  = '0;
            m_cap_sec  = '0;
            m_cap_sub  = '0;
            sclk_q     = 1'b0;
            cs_q       = 1'b1;
            pps_q      = 1'b0;
            nbits      = 0;
            irq_wait   = 0;
            reset_wait = 2;
        end else begin
            if (reset_wait != 0) begin
                reset_wait--;
                if (reset_wait == 0) check_outputs();
            end
            if (!sys_status.sync_locked || !sys_status.dpll_locked) m_err_cnt++;
            if (sys_status.phase_error > `TC_PHASE_ERR_LIMIT && m_irq.on_error) begin
                m_irq_st[1] = 1'b1;
            end
            if (sys_status.pps && !pps_q) begin     // PPS rise
                m_pps_cnt++;
                m_cap_sec = sys_status.seconds[31:0];
                m_cap_sub = sys_status.subseconds;
                if (m_irq.on_pps) m_irq_st[0] = 1'b1;
                irq_wait = 8;
            end else if (irq_wait != 0) begin
                irq_wait--;
                if (irq_wait == 0) begin
                    check_value("irq_n after PPS", 64'(irq_n),
                                64'(!(m_irq.enable && (m_irq_st != 2'b00))));
                end
            end
            if (cs_q && !spi_cs_n) nbits = 0;       // Frame start
            if (!spi_cs_n && spi_sclk && !sclk_q) begin
                mosi_bits = {mosi_bits[46:0], spi_mosi};
                miso_bits = {miso_bits[46:0], spi_miso};
                nbits++;
            end
            if (!cs_q && spi_cs_n) end_frame();
            sclk_q = spi_sclk;
            cs_q   = spi_cs_n;
            pps_q  = sys_status.pps;
        end
    end

endmodule

`default_nettype wire

/* source/timing_ctrl_top.sv */
// Top level of the timing receiver SPI block
// SPI slave, configuration registers and status monitor

`default_nettype none

module timing_ctrl_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                spi_sclk,
    input  wire                                spi_mosi,
    input  wire                                spi_cs_n,
    output logic                               spi_miso,
    output logic                               irq_n,
    input  wire timing_ctrl_pkg::time_status_t sys_status,
    output timing_ctrl_pkg::delay_cfg_t        delay_cfg,
    output timing_ctrl_pkg::dpll_cfg_t         dpll_cfg,
    output timing_ctrl_pkg::gnss_ctrl_t        gnss_ctrl,
    output timing_ctrl_pkg::pps_sel_t          pps_sel
);
    import timing_ctrl_pkg::*;

    cfg_wr_t  cfg_wr;       // Write pulse
    stat_rd_t stat_rd;      // Status read pulse
    word_t    rd_data;
    irq_cfg_t irq_cfg;
    logic     err_clear;

    spi_slave u_spi_slave (
        .clk(clk), .rst_n(rst_n),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .spi_miso(spi_miso),
        .cfg_wr(cfg_wr), .stat_rd(stat_rd), .rd_data(rd_data)
    );

    config_regs u_config_regs (
        .clk(clk), .rst_n(rst_n), .cfg_wr(cfg_wr),
        .delay_cfg(delay_cfg), .dpll_cfg(dpll_cfg), .gnss_ctrl(gnss_ctrl), .pps_sel(pps_sel),
        .irq_cfg(irq_cfg), .err_clear(err_clear)
    );

    status_monitor u_status_monitor (
        .clk(clk), .rst_n(rst_n), .sys_status(sys_status), .irq_cfg(irq_cfg),
        .err_clear(err_clear), .stat_rd(stat_rd), .gnss_enable(gnss_ctrl.enable),
        .rd_data(rd_data), .irq_n(irq_n)
    );

endmodule

`default_nettype wire

/* source/status_monitor.sv */
// Status side of the SPI block
// PPS edge capture, PPS and error counters, interrupt status, irq_n, read mux

`default_nettype none

`include "timing_ctrl_macros.svh"

module status_monitor (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire timing_ctrl_pkg::time_status_t sys_status,
    input  wire timing_ctrl_pkg::irq_cfg_t   irq_cfg,
    input  wire                              err_clear,
    input  wire timing_ctrl_pkg::stat_rd_t   stat_rd,
    input  wire                              gnss_enable,
    output timing_ctrl_pkg::word_t           rd_data,
    output logic                             irq_n
);
    import timing_ctrl_pkg::*;

    logic       pps_q;
    logic       pps_qq;
    logic       pps_edge;
    word_t      cap_sec;        // Seconds low word at last PPS
    word_t      cap_subsec;
    word_t      pps_cnt;
    word_t      err_cnt;
    logic [1:0] irq_status;     // Bit 0 PPS, bit 1 phase error
    word_t      status_word;

    // ====================
    // PPS edge and capture
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pps_q      <= 1'b0;
            pps_qq     <= 1'b0;
            cap_sec    <= '0;
            cap_subsec <= '0;
            pps_cnt    <= '0;
        end else begin
            pps_q  <= sys_status.pps;
            pps_qq <= pps_q;
            if (pps_edge) begin
                cap_sec    <= sys_status.seconds[`TC_DATA_W-1:0];
                cap_subsec <= sys_status.subseconds;
                pps_cnt    <= pps_cnt + 1'b1;
            end
        end
    end

    assign pps_edge = pps_q & ~pps_qq;      // One cycle after pps rises

    // ====================
    // Errors and interrupts
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_cnt    <= '0;
            irq_status <= '0;
            irq_n      <= 1'b1;
        end else begin
            if (err_clear) begin
                err_cnt <= '0;
            end else if (!sys_status.sync_locked || !sys_status.dpll_locked) begin
                err_cnt <= err_cnt + 1'b1;  // Cycles without lock
            end
            if (pps_edge && irq_cfg.on_pps) irq_status[0] <= 1'b1;
            if (sys_status.phase_error > `TC_PHASE_ERR_LIMIT && irq_cfg.on_error) begin
                irq_status[1] <= 1'b1;
            end
            if (stat_rd.valid && stat_rd.addr == 12'd0) irq_status <= '0;  // Clear on read
            irq_n <= ~(irq_cfg.enable && |irq_status);
        end
    end

    // ====================
    // Read mux
    // ====================
    assign status_word = {22'd0, irq_status, 2'd0, gnss_enable, 1'b0,
                          sys_status.dpll_locked, sys_status.sync_locked,
                          sys_status.pps, 1'b1};

    always_comb begin
        case (stat_rd.addr)
            12'd0:   rd_data = status_word;
            12'd1:   rd_data = word_t'(sys_status.seconds[7:0]);
            12'd2:   rd_data = sys_status.seconds[`TC_SEC_W-1:8];
            12'd3:   rd_data = sys_status.subseconds;
            12'd4:   rd_data = sys_status.phase_error;
            12'd5:   rd_data = sys_status.frequency_error;
            12'd6:   rd_data = err_cnt;
            12'd7:   rd_data = pps_cnt;
            12'd8:   rd_data = cap_sec;
            12'd9:   rd_data = cap_subsec;
            default: rd_data = '0;
        endcase
    end

    // Interrupt line stays released whenever config_regs has it disabled
    assert property (@(posedge clk) disable iff (!rst_n) !irq_cfg.enable |=> irq_n)
        else $error("irq_n low after irq enable was off");

endmodule

`default_nettype wire

/* source/config_regs.sv */
// Configuration registers written over SPI
// Delay, DPLL, GNSS, PPS select and interrupt settings, error counter clear

`default_nettype none

`include "timing_ctrl_macros.svh"

module config_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire timing_ctrl_pkg::cfg_wr_t cfg_wr,
    output timing_ctrl_pkg::delay_cfg_t  delay_cfg,
    output timing_ctrl_pkg::dpll_cfg_t   dpll_cfg,
    output timing_ctrl_pkg::gnss_ctrl_t  gnss_ctrl,
    output timing_ctrl_pkg::pps_sel_t    pps_sel,
    output timing_ctrl_pkg::irq_cfg_t    irq_cfg,
    output logic                         err_clear     // Pulse to status_monitor
);
    import timing_ctrl_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delay_cfg   <= '0;
            dpll_cfg.kp <= `TC_KP_DEFAULT;
            dpll_cfg.ki <= `TC_KI_DEFAULT;
            gnss_ctrl   <= '{enable: 1'b0, mode: 3'd0, reset_n: 1'b1};
            pps_sel     <= '{source: 2'd0, auto_enable: 1'b1};  // Auto select on
            irq_cfg     <= '0;
            err_clear   <= 1'b0;
        end else begin
            err_clear <= 1'b0;
            if (cfg_wr.valid) begin
                case (cfg_wr.kind)
                    DELAY: begin
                        if (cfg_wr.addr == 12'd0) delay_cfg.cable_ns   <= cfg_wr.data;
                        if (cfg_wr.addr == 12'd1) delay_cfg.antenna_ns <= cfg_wr.data;
                    end
                    GNSS: begin
                        if (cfg_wr.addr == 12'd0) gnss_ctrl.enable  <= cfg_wr.data[0];
                        if (cfg_wr.addr == 12'd1) gnss_ctrl.mode    <= cfg_wr.data[2:0];
                        if (cfg_wr.addr == 12'd2) gnss_ctrl.reset_n <= cfg_wr.data[0];
                    end
                    DPLL: begin
                        if (cfg_wr.addr == 12'd0) dpll_cfg.kp <= cfg_wr.data;
                        if (cfg_wr.addr == 12'd1) dpll_cfg.ki <= cfg_wr.data;
                    end
                    PPS_SEL: begin
                        if (cfg_wr.addr == 12'd0) pps_sel.source      <= cfg_wr.data[1:0];
                        if (cfg_wr.addr == 12'd1) pps_sel.auto_enable <= cfg_wr.data[0];
                    end
                    CONFIG: begin
                        if (cfg_wr.addr == 12'd1) irq_cfg.enable <= cfg_wr.data[0];
                        if (cfg_wr.addr == 12'd2) begin
                            irq_cfg.on_pps   <= cfg_wr.data[0];
                            irq_cfg.on_error <= cfg_wr.data[1];
                        end
                        err_clear <= (cfg_wr.addr == 12'd3);   // Error counter reset
                    end
                    default: ;      // Reserved kinds
                endcase
            end
        end
    end

    // Clear stays a pulse while the SPI side only sends pulsed writes
    assert property (@(posedge clk) disable iff (!rst_n) err_clear |=> !err_clear)
        else $error("err_clear held longer than one cycle");

endmodule

`default_nettype wire

/* source/spi_slave.sv */
// SPI slave, mode 0, MSB first
// Pin synchronizer, frame FSM, shift registers, write and read request pulses

`default_nettype none

`include "timing_ctrl_macros.svh"

module spi_slave (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         spi_sclk,
    input  wire                         spi_mosi,
    input  wire                         spi_cs_n,
    output logic                        spi_miso,
    output timing_ctrl_pkg::cfg_wr_t    cfg_wr,     // Write pulse to config_regs
    output timing_ctrl_pkg::stat_rd_t   stat_rd,    // Read pulse to status_monitor
    input  wire timing_ctrl_pkg::word_t rd_data     // Same-cycle answer to stat_rd
);
    import timing_ctrl_pkg::*;

    // ====================
    // Pin synchronizer
    // ====================
    logic [`TC_SYNC_STAGES-1:0] sclk_sync;
    logic [`TC_SYNC_STAGES-1:0] mosi_sync;
    logic [`TC_SYNC_STAGES-1:0] cs_sync;
    logic                       sclk_prev;      // For edge detect
    logic                       sclk_rise;
    logic                       sclk_fall;
    logic                       mosi_s;
    logic                       cs_active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            cs_sync   <= '1;    // Deselected
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[`TC_SYNC_STAGES-2:0], spi_sclk};
            mosi_sync <= {mosi_sync[`TC_SYNC_STAGES-2:0], spi_mosi};
            cs_sync   <= {cs_sync[`TC_SYNC_STAGES-2:0], spi_cs_n};
            sclk_prev <= sclk_sync[`TC_SYNC_STAGES-1];
        end
    end

    assign sclk_rise = sclk_sync[`TC_SYNC_STAGES-1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[`TC_SYNC_STAGES-1] & sclk_prev;
    assign mosi_s    = mosi_sync[`TC_SYNC_STAGES-1];
    assign cs_active = ~cs_sync[`TC_SYNC_STAGES-1];

    // ====================
    // Frame FSM
    // ====================
    spi_state_e           state;
    logic [4:0]           bit_cnt;          // Bits within cmd or data phase
    logic [`TC_CMD_W-1:0] cmd_sr;
    logic [`TC_CMD_W-1:0] cmd_next;         // Command incl. bit on this rise
    cmd_kind_e            kind_next;
    logic                 is_read;
    logic                 tx_load;          // Read data lands this cycle
    word_t                rx_sr;
    word_t                tx_sr;

    assign cmd_next  = {cmd_sr[`TC_CMD_W-2:0], mosi_s};
    assign kind_next = cmd_kind_e'(cmd_next[14:12]);
    assign is_read   = cmd_next[`TC_CMD_W-1] || (kind_next == STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            cmd_sr   <= '0;
            rx_sr    <= '0;
            tx_sr    <= '0;
            tx_load  <= 1'b0;
            spi_miso <= 1'b0;
            cfg_wr   <= '0;
            stat_rd  <= '0;
        end else begin
            cfg_wr.valid  <= 1'b0;      // Requests are single pulses
            stat_rd.valid <= 1'b0;
            tx_load       <= 1'b0;
            if (!cs_active) begin       // cs_n high aborts any frame
                state    <= IDLE;
                bit_cnt  <= '0;
                spi_miso <= 1'b0;
            end else begin
                case (state)
                    IDLE: begin
                        state   <= CMD;
                        bit_cnt <= '0;
                    end
                    CMD: begin
                        if (sclk_rise) begin
                            cmd_sr  <= cmd_next;
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd15) begin      // 16th command bit
                                bit_cnt <= '0;
                                if (is_read) begin
                                    state         <= DATA_OUT;
                                    tx_load       <= 1'b1;
                                    stat_rd.valid <= (kind_next == STATUS);
                                    stat_rd.addr  <= cmd_next[`TC_ADDR_W-1:0];
                                end else begin
                                    state <= DATA_IN;
                                end
                            end
                        end
                    end
                    DATA_IN: begin
                        if (sclk_rise) begin
                            rx_sr   <= {rx_sr[`TC_DATA_W-2:0], mosi_s};
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd31) begin      // Last data bit
                                cfg_wr.valid <= 1'b1;
                                cfg_wr.kind  <= cmd_kind_e'(cmd_sr[14:12]);
                                cfg_wr.addr  <= cmd_sr[`TC_ADDR_W-1:0];
                                cfg_wr.data  <= {rx_sr[`TC_DATA_W-2:0], mosi_s};
                                state        <= DONE;
                            end
                        end
                    end
                    DATA_OUT: begin
                        if (tx_load) begin
                            tx_sr <= stat_rd.valid ? rd_data : '0;  // Non-status kinds read zero
                        end else if (sclk_fall) begin
                            spi_miso <= tx_sr[`TC_DATA_W-1];
                            tx_sr    <= {tx_sr[`TC_DATA_W-2:0], 1'b0};
                            bit_cnt  <= bit_cnt + 5'd1;
                            if (bit_cnt == 5'd31) begin
                                state <= DONE;
                            end
                        end
                    end
                    DONE:    state <= DONE;     // Hold until cs_n rises
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Write and read paths of the FSM never fire together
    assert property (@(posedge clk) disable iff (!rst_n) !(cfg_wr.valid && stat_rd.valid))
        else $error("cfg_wr and stat_rd valid in the same cycle");

endmodule

`default_nettype wire

/* source/timing_ctrl_pkg.sv */
// Types for the timing receiver SPI block
// Vector typedefs, command and FSM enums, request and config structs

`default_nettype none

`include "timing_ctrl_macros.svh"

package timing_ctrl_pkg;

    // ====================
    // Plain vectors
    // ====================
    typedef logic [`TC_DATA_W-1:0] word_t;
    typedef logic [`TC_ADDR_W-1:0] reg_addr_t;
    typedef logic [`TC_SEC_W-1:0]  seconds_t;

    // Command kind, bits 14:12 of the frame; 0 and 6 reserved
    typedef enum logic [2:0] {
        STATUS  = 3'd1,
        CONFIG  = 3'd2,
        DELAY   = 3'd3,
        GNSS    = 3'd4,
        DPLL    = 3'd5,
        PPS_SEL = 3'd7
    } cmd_kind_e;

    // Frame FSM
    typedef enum logic [2:0] {IDLE, CMD, DATA_IN, DATA_OUT, DONE} spi_state_e;

    // ====================
    // Requests
    // ====================
    typedef struct packed {
        logic      valid;   // One-cycle pulse
        cmd_kind_e kind;
        reg_addr_t addr;
        word_t     data;
    } cfg_wr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
    } stat_rd_t;

    // System status from the timing core
    typedef struct packed {
        logic     pps;
        logic     sync_locked;
        logic     dpll_locked;
        seconds_t seconds;
        word_t    subseconds;
        word_t    phase_error;
        word_t    frequency_error;
    } time_status_t;

    // ====================
    // Configuration
    // ====================
    typedef struct packed {
        word_t cable_ns;
        word_t antenna_ns;
    } delay_cfg_t;

    typedef struct packed {
        word_t kp;      // 16.16
        word_t ki;      // 16.16
    } dpll_cfg_t;

    typedef struct packed {
        logic       enable;
        logic [2:0] mode;
        logic       reset_n;    // Receiver reset, active low
    } gnss_ctrl_t;

    typedef struct packed {
        logic [1:0] source;
        logic       auto_enable;
    } pps_sel_t;

    typedef struct packed {
        logic enable;
        logic on_pps;
        logic on_error;
    } irq_cfg_t;

endpackage

`default_nettype wire

/* source/timing_ctrl_macros.svh */
// Widths, reset defaults and limits for the timing receiver SPI block
// Shared by the package and the RTL modules

`ifndef TIMING_CTRL_MACROS_SVH
`define TIMING_CTRL_MACROS_SVH

// Bus and frame widths
`define TC_DATA_W       32      // Data word
`define TC_CMD_W        16      // Command frame
`define TC_ADDR_W       12      // Address field of the command
`define TC_SEC_W        40      // Seconds counter

// Pin synchronizer depth
`define TC_SYNC_STAGES  3

// Phase error threshold for the error interrupt
`define TC_PHASE_ERR_LIMIT  32'd10000

// DPLL gains after reset, 16.16 fixed point
`define TC_KP_DEFAULT   32'h0001_0000   // 1.0
`define TC_KI_DEFAULT   32'h0000_0100   // 1/256

`endif
